//--- Makefile
# Verilator build and run of the Microroc testbench

VERILATOR ?= verilator
TOP ?= microrocTb
FLAGS ?= --binary --assert

OBJ_DIR := obj_dir
SIM := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a listed source changes
$(SIM): tb.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f tb.f -Mdir $(OBJ_DIR)

# Exit status is nonzero when the testbench stops with $fatal
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- source/daqControl.sv
`timescale 1ns/10ps
`default_nettype none

module daqControl import microrocPkg::*; (
   input  wire             Clk,
   input  wire             arstN,
   input  wire             acqStart,     // One-cycle pulse
   input  wire [15:0]      acqTime,      // START_ACQ length in cycles
   input  wire             endReadout,
   input  wire             trailerTaken,
   output pwrOnT           pwrOn,
   output logic            startAcq,
   output logic            startReadout,
   output fifoWordT        trailerWord,
   output logic            onceEnd
);

   typedef enum logic [2:0] {
      sIdle,
      sSettle,    // Supplies ramping
      sAcquire,   // START_ACQ high
      sReadout,   // Waiting for end of readout
      sTrailer    // Trailer offered to the arbiter
   } daqStateT;

   daqStateT state;
   logic [15:0] downCnt;                   // Shared by settle and acquire
   logic [CountBits-1:0] cycleCnt;         // Completed acquisition cycles
   logic trailerValid;

   assign trailerWord = '{data: {TrailerTag, cycleCnt}, valid: trailerValid};

   //////////////////////////////
   // Acquisition sequencer
   //////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         state <= sIdle;
         downCnt <= '0;
         cycleCnt <= '0;
         trailerValid <= 1'b0;
         pwrOn <= '0;
         startAcq <= 1'b0;
         startReadout <= 1'b0;
         onceEnd <= 1'b0;
      end else begin
         startReadout <= 1'b0;               // Pulses by default
         onceEnd <= 1'b0;
         unique case (state)
            sIdle: if (acqStart) begin
               pwrOn <= '1;                   // All four domains together
               downCnt <= 16'(PwrSettle - 1);
               state <= sSettle;
            end
            sSettle: if (downCnt == '0) begin
               startAcq <= 1'b1;
               downCnt <= acqTime - 16'd1;
               state <= sAcquire;
            end else begin
               downCnt <= downCnt - 16'd1;
            end
            sAcquire: if (downCnt == '0) begin
               startAcq <= 1'b0;
               startReadout <= 1'b1;
               state <= sReadout;
            end else begin
               downCnt <= downCnt - 16'd1;
            end
            sReadout: if (endReadout) begin
               cycleCnt <= cycleCnt + 1'b1;   // First cycle reports 1
               trailerValid <= 1'b1;
               state <= sTrailer;
            end
            sTrailer: if (trailerTaken) begin
               trailerValid <= 1'b0;
               onceEnd <= 1'b1;
               pwrOn <= '0;                   // Power pulsing off with the trailer
               state <= sIdle;
            end
            default: state <= sIdle;
         endcase
      end
   end

   // Acquisition only on settled supplies
   acqPowered: assert property (@(posedge Clk) disable iff (!arstN)
      $rose(startAcq) |-> (&pwrOn) && $past(&pwrOn, PwrSettle));

endmodule

`default_nettype wire

//--- source/fifoArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module fifoArbiter import microrocPkg::*; (
   input  wire                   Clk,
   input  wire                   arstN,
   input  wire fifoWordT         rdWord,       // Priority source
   input  wire fifoWordT         trailerWord,
   input  wire                   fifoFull,
   output logic                  rdTaken,
   output logic                  trailerTaken,
   output logic [WordBits-1:0]   fifoData,
   output logic                  fifoWrEn
);

   // Readout first, trailer only on a free slot
   assign rdTaken = !fifoFull && rdWord.valid;
   assign trailerTaken = !fifoFull && !rdWord.valid && trailerWord.valid;

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN)
         fifoWrEn <= 1'b0;
      else
         fifoWrEn <= rdTaken || trailerTaken; // Write one cycle after grant
   end

   always_ff @(posedge Clk) begin
      if (rdTaken)
         fifoData <= rdWord.data;
      else if (trailerTaken)
         fifoData <= trailerWord.data;
   end

   // One grant per cycle across both sources
   singleGrant: assert property (@(posedge Clk) disable iff (!arstN)
      !(rdTaken && trailerTaken));

endmodule

`default_nettype wire

//--- source/holdGen.sv
`timescale 1ns/10ps
`default_nettype none

module holdGen (
   input  wire          Clk,
   input  wire          arstN,
   input  wire          trigIn,
   input  wire          holdEn,
   input  wire [7:0]    holdDelay,  // Edge to HOLD minus one
   input  wire [15:0]   holdTime,   // HOLD width
   output logic         hold
);

   typedef enum logic [1:0] {
      hIdle,
      hDelay,   // Pending
      hHigh
   } holdStateT;

   holdStateT state;
   logic [15:0] cnt;
   logic trigDly;
   logic trigEdge;

   assign trigEdge = trigIn && !trigDly && holdEn;

   //////////////////////////////
   // Delay then width
   //////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         state <= hIdle;
         cnt <= '0;
         trigDly <= 1'b0;
         hold <= 1'b0;
      end else begin
         trigDly <= trigIn;
         unique case (state)
            hIdle: if (trigEdge) begin
               cnt <= {8'd0, holdDelay};
               state <= hDelay;
            end
            hDelay: if (cnt == '0) begin
               hold <= 1'b1;
               cnt <= holdTime - 16'd1;
               state <= hHigh;
            end else begin
               cnt <= cnt - 16'd1;
            end
            hHigh: if (cnt == '0) begin
               hold <= 1'b0;                  // Retriggers ignored until here
               state <= hIdle;
            end else begin
               cnt <= cnt - 16'd1;
            end
            default: state <= hIdle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/microrocPkg.sv
`default_nettype none

package microrocPkg;

   //////////////////////////////
   // Sizes and timing
   //////////////////////////////
   localparam int SrBits = 64;              // Bits per serial load
   localparam int WordBits = 16;            // Readout word width
   localparam int PwrSettle = 4;            // Power-on to START_ACQ in Clk cycles
   localparam logic [3:0] TrailerTag = 4'hE; // Upper nibble of the trailer
   localparam int CountBits = 12;           // Event counter in the trailer

   //////////////////////////////
   // ASIC register images
   //////////////////////////////
   // Configuration word, MSB shifted first
   typedef struct packed {
      logic [9:0] dac2Vth;      // Third threshold
      logic [9:0] dac1Vth;      // Second threshold
      logic [9:0] dac0Vth;      // First threshold
      logic [7:0] header;       // Chip ID in the data frames
      logic [1:0] enDout;
      logic [1:0] enTransmitOn;
      logic [13:0] swGain;      // Low/high gain switches
      logic enDac;
      logic enBg;               // Bandgap
      logic enOtaq;
      logic enDiscri0;
      logic enDiscri1;
      logic enDiscri2;
      logic enTrigOut;
      logic scOn;
   } scConfigT;

   // One shift word, seen as config or as read-register mask
   typedef union packed {
      scConfigT scConfig;
      logic [SrBits-1:0] readReg; // One bit per channel
   } srWordU;

   //////////////////////////////
   // Pins and words
   //////////////////////////////
   typedef struct packed {
      logic digital;
      logic analog;
      logic adc;
      logic dac;
   } pwrOnT;

   // Word offered to the FIFO arbiter
   typedef struct packed {
      logic [WordBits-1:0] data;
      logic valid;              // Held until taken
   } fifoWordT;

endpackage

`default_nettype wire

//--- source/microrocTop.sv
`timescale 1ns/10ps
`default_nettype none

module microrocTop import microrocPkg::*; (
   input  wire                   Clk,
   input  wire                   arstN,
   // Host side
   input  wire                   scOrRead,
   input  wire                   startLoad,
   input  wire scConfigT         scConfig,
   input  wire [SrBits-1:0]      readReg,
   input  wire                   acqStart,
   input  wire [15:0]            acqTime,
   input  wire [15:0]            holdTime,
   input  wire [7:0]             holdDelay,
   input  wire                   holdEn,
   input  wire                   trigIn,
   input  wire                   fifoFull,
   output logic                  configDone,
   output logic                  onceEnd,
   output logic                  overflow,
   // FIFO side
   output logic [WordBits-1:0]   fifoData,
   output logic                  fifoWrEn,
   // ASIC pins
   output logic                  select,
   output logic                  srRstB,
   output logic                  srCk,
   output logic                  srIn,
   output pwrOnT                 pwrOn,
   output logic                  startAcq,
   output logic                  startReadout,
   output logic                  hold,
   input  wire                   endReadout,
   input  wire                   doutB,
   input  wire                   transmitOnB
);

   fifoWordT rdWord;       // RAM readout to arbiter
   fifoWordT trailerWord;  // End of cycle to arbiter
   logic rdTaken;
   logic trailerTaken;

   //////////////////////////////
   // Blocks
   //////////////////////////////
   slowControl slowControl_inst (
      .Clk(Clk), .arstN(arstN),
      .startLoad(startLoad), .scOrRead(scOrRead),
      .scConfig(scConfig), .readReg(readReg),
      .select(select), .srRstB(srRstB), .srCk(srCk), .srIn(srIn),
      .configDone(configDone)
   );

   daqControl daqControl_inst (
      .Clk(Clk), .arstN(arstN),
      .acqStart(acqStart), .acqTime(acqTime),
      .endReadout(endReadout), .trailerTaken(trailerTaken),
      .pwrOn(pwrOn), .startAcq(startAcq), .startReadout(startReadout),
      .trailerWord(trailerWord), .onceEnd(onceEnd)
   );

   ramReadout ramReadout_inst (
      .Clk(Clk), .arstN(arstN),
      .doutB(doutB), .transmitOnB(transmitOnB),
      .rdTaken(rdTaken), .rdWord(rdWord), .overflow(overflow)
   );

   fifoArbiter fifoArbiter_inst (
      .Clk(Clk), .arstN(arstN),
      .rdWord(rdWord), .trailerWord(trailerWord), .fifoFull(fifoFull),
      .rdTaken(rdTaken), .trailerTaken(trailerTaken),
      .fifoData(fifoData), .fifoWrEn(fifoWrEn)
   );

   holdGen holdGen_inst (
      .Clk(Clk), .arstN(arstN),
      .trigIn(trigIn), .holdEn(holdEn),
      .holdDelay(holdDelay), .holdTime(holdTime),
      .hold(hold)
   );

endmodule

`default_nettype wire

//--- source/ramReadout.sv
`timescale 1ns/10ps
`default_nettype none

module ramReadout import microrocPkg::*; (
   input  wire         Clk,
   input  wire         arstN,
   input  wire         doutB,        // Serial data, active low
   input  wire         transmitOnB,  // Frame enable, active low
   input  wire         rdTaken,
   output fifoWordT    rdWord,
   output logic        overflow      // Sticky
);

   logic [WordBits-1:0] shiftReg;
   logic [WordBits-1:0] nextWord;
   logic [WordBits-1:0] bufData;
   logic [$clog2(WordBits)-1:0] bitCnt;
   logic bufValid;
   logic wordDone;
   logic bufLoad;

   assign nextWord = {shiftReg[WordBits-2:0], ~doutB}; // MSB arrives first
   assign wordDone = !transmitOnB && (bitCnt == '1);   // Sixteenth bit now
   assign bufLoad = wordDone && (!bufValid || rdTaken);
   assign rdWord = '{data: bufData, valid: bufValid};

   //////////////////////////////
   // Bit count and buffer state
   //////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         bitCnt <= '0;
         bufValid <= 1'b0;
         overflow <= 1'b0;
      end else begin
         if (transmitOnB)
            bitCnt <= '0;                    // Realign on every frame
         else
            bitCnt <= bitCnt + 1'b1;
         if (bufLoad)
            bufValid <= 1'b1;
         else if (rdTaken)
            bufValid <= 1'b0;
         if (wordDone && !bufLoad)
            overflow <= 1'b1;                // New word dropped
      end
   end

   always_ff @(posedge Clk) begin
      if (!transmitOnB)
         shiftReg <= nextWord;
      if (bufLoad)
         bufData <= nextWord;
   end

   // ASIC cannot wait, the arbiter must keep up
   noOverrun: assert property (@(posedge Clk) disable iff (!arstN)
      wordDone |-> !bufValid || rdTaken);

endmodule

`default_nettype wire

//--- source/slowControl.sv
`timescale 1ns/10ps
`default_nettype none

module slowControl import microrocPkg::*; (
   input  wire                Clk,
   input  wire                arstN,
   input  wire                startLoad,  // One-cycle pulse
   input  wire                scOrRead,   // 1 selects read register
   input  wire scConfigT      scConfig,
   input  wire [SrBits-1:0]   readReg,
   output logic               select,
   output logic               srRstB,
   output logic               srCk,
   output logic               srIn,
   output logic               configDone
);

   srWordU srWord;                         // Shift register, MSB goes out first
   logic [$clog2(SrBits+1)-1:0] bitCnt;    // Bits already clocked out
   logic busy;

   assign srRstB = arstN;                  // ASIC register follows FPGA reset
   assign srIn = busy & srWord.readReg[SrBits-1];

   //////////////////////////////
   // Bit-period sequencer
   //////////////////////////////
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         busy <= 1'b0;
         select <= 1'b0;
         srCk <= 1'b0;
         bitCnt <= '0;
         configDone <= 1'b0;
      end else begin
         configDone <= 1'b0;
         if (!busy) begin
            if (startLoad) begin
               busy <= 1'b1;
               select <= scOrRead;            // Register choice for the ASIC
               srCk <= 1'b0;
               bitCnt <= '0;
            end
         end else if (bitCnt == SrBits) begin
            busy <= 1'b0;                    // One spare cycle after last fall
            configDone <= 1'b1;
         end else if (!srCk) begin
            srCk <= 1'b1;                    // Data settled, ASIC samples now
         end else begin
            srCk <= 1'b0;
            bitCnt <= bitCnt + 1'b1;
         end
      end
   end

   // Shift word, written through either view of the union
   always_ff @(posedge Clk) begin
      if (!busy && startLoad) begin
         if (scOrRead)
            srWord.readReg <= readReg;
         else
            srWord.scConfig <= scConfig;
      end else if (busy && srCk) begin
         srWord.readReg <= {srWord.readReg[SrBits-2:0], 1'b0}; // Next bit on falling srCk
      end
   end

   // No stray clock edges into the ASIC between loads
   idleClockLow: assert property (@(posedge Clk) disable iff (!arstN)
      !busy |-> !srCk);

endmodule

`default_nettype wire

//--- tb.f
source/microrocPkg.sv
source/slowControl.sv
source/daqControl.sv
source/ramReadout.sv
source/fifoArbiter.sv
source/holdGen.sv
source/microrocTop.sv
testbench/microrocTb.sv

//--- testbench/microrocTb.sv
`timescale 1ns/10ps
`default_nettype none

module microrocTb import microrocPkg::*; ();

   //////////////////////////////
   // Run limits
   //////////////////////////////
   localparam int Seed = 92059;
   localparam int ResetCycles = 5;
   localparam int LoadCycles = 2 * SrBits + 4;                  // One serial load
   localparam int AcqCycles = PwrSettle + 20 + 4;
   localparam int ReadCycles = 5 * (WordBits + 2) + 8;          // Five words with short gaps
   localparam int PressCycles = AcqCycles + 3 * (WordBits + 24) + 8;
   localparam int HoldCycles = 80;
   localparam int CycleLimit = ResetCycles + 2 * LoadCycles + AcqCycles + ReadCycles
                               + PressCycles + HoldCycles + 200;

   logic Clk = 1'b0;
   logic arstN;
   logic scOrRead, startLoad, acqStart, holdEn, trigIn, fifoFull;
   scConfigT scConfig;
   logic [SrBits-1:0] readReg;
   logic [15:0] acqTime, holdTime;
   logic [7:0] holdDelay;
   logic configDone, onceEnd, overflow, fifoWrEn;
   logic [WordBits-1:0] fifoData;
   logic select, srRstB, srCk, srIn, startAcq, startReadout, hold;
   pwrOnT pwrOn;
   logic endReadout, doutB, transmitOnB;       // Driven by the ASIC model

   logic [SrBits-1:0] capturedWord;            // ASIC shift register image
   logic [WordBits-1:0] modelQ[$];             // Words the ASIC will send
   logic [WordBits-1:0] expQ[$];
   logic [WordBits-1:0] fifoQ[$];              // Words seen at the FIFO port
   int wordGap = 2;                            // Idle cycles between frames
   int cycleCount = 0;

   always #2 Clk = ~Clk;                       // 4 ns period

   microrocTop microrocTop_inst (
      .Clk(Clk), .arstN(arstN),
      .scOrRead(scOrRead), .startLoad(startLoad), .scConfig(scConfig), .readReg(readReg),
      .acqStart(acqStart), .acqTime(acqTime), .holdTime(holdTime), .holdDelay(holdDelay),
      .holdEn(holdEn), .trigIn(trigIn), .fifoFull(fifoFull),
      .configDone(configDone), .onceEnd(onceEnd), .overflow(overflow),
      .fifoData(fifoData), .fifoWrEn(fifoWrEn),
      .select(select), .srRstB(srRstB), .srCk(srCk), .srIn(srIn), .pwrOn(pwrOn),
      .startAcq(startAcq), .startReadout(startReadout), .hold(hold),
      .endReadout(endReadout), .doutB(doutB), .transmitOnB(transmitOnB)
   );

   //////////////////////////////
   // ASIC model and FIFO monitor
   //////////////////////////////
   always @(posedge srCk)
      capturedWord <= {capturedWord[SrBits-2:0], srIn};  // MSB arrives first

   always @(posedge Clk)
      if (arstN && fifoWrEn)
         fifoQ.push_back(fifoData);

   task automatic serialiseWords();
      logic [WordBits-1:0] w;
      #1;
      while (modelQ.size() > 0) begin
         w = modelQ.pop_front();
         for (int b = WordBits - 1; b >= 0; b--) begin
            transmitOnB = 1'b0;
            doutB = ~w[b];                     // Pins are active low
            @(posedge Clk);
            #1;
         end
         transmitOnB = 1'b1;
         doutB = 1'b1;
         repeat (wordGap) begin
            @(posedge Clk);
            #1;
         end
      end
      endReadout = 1'b1;                       // End of the RAM readout
      @(posedge Clk);
      #1;
      endReadout = 1'b0;
   endtask

   initial begin
      endReadout = 1'b0;
      doutB = 1'b1;
      transmitOnB = 1'b1;
      forever begin
         @(posedge Clk);
         if (startReadout)
            serialiseWords();
      end
   end

   //////////////////////////////
   // Timeout
   //////////////////////////////
   always @(posedge Clk) begin
      cycleCount++;
      if (cycleCount > CycleLimit) begin
         $display("Timeout after %0d cycles, the DUT stopped responding", CycleLimit);
         abortRun();
      end
   end

   //////////////////////////////
   // Helpers and compare tasks
   //////////////////////////////
   task automatic abortRun();
      $display("Test FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic nextCycle();
      @(posedge Clk);
      #1;                                      // Drive and sample point
   endtask

   task automatic checkConfig(string testName, scConfigT expected, scConfigT actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkReadReg(string testName, logic [SrBits-1:0] expected,
                               logic [SrBits-1:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkWord(string testName, logic [WordBits-1:0] expected,
                            logic [WordBits-1:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkCycles(string testName, int expected, int actual);
      if (actual != expected) begin
         $display("ERROR %s: expected %0d, actual %0d", testName, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkPower(string testName, pwrOnT expected, pwrOnT actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %b, actual %b", testName, expected, actual);
         abortRun();
      end
   endtask

   task automatic checkBit(string testName, logic expected, logic actual);
      if (actual !== expected) begin
         $display("ERROR %s: expected %b, actual %b", testName, expected, actual);
         abortRun();
      end
   endtask

   task automatic queueWords(int count);
      logic [WordBits-1:0] w;
      repeat (count) begin
         w = WordBits'($urandom);
         modelQ.push_back(w);
         expQ.push_back(w);
      end
   endtask

   // Trailer closes the cycle and power drops with onceEnd
   task automatic waitCycleEnd(string testName);
      while (!onceEnd)
         nextCycle();
      checkPower({testName, " power off"}, pwrOnT'(4'h0), pwrOn);
      nextCycle();
      checkBit({testName, " onceEnd pulse"}, 1'b0, onceEnd);
   endtask

   task automatic checkReceived(string testName, int cycleNo);
      logic [WordBits-1:0] trailer;
      trailer = {TrailerTag, CountBits'(cycleNo)};
      checkCycles({testName, " word count"}, expQ.size() + 1, fifoQ.size());
      while (expQ.size() > 0)
         checkWord({testName, " data"}, expQ.pop_front(), fifoQ.pop_front());
      checkWord({testName, " trailer"}, trailer, fifoQ.pop_front());
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////
   task automatic testConfigLoad();
      scConfigT cfg;
      int n;
      cfg = {$urandom, $urandom};
      scConfig = cfg;
      scOrRead = 1'b0;
      startLoad = 1'b1;
      nextCycle();
      startLoad = 1'b0;
      checkBit("testConfigLoad select", 1'b0, select);
      n = 0;
      while (!configDone) begin
         nextCycle();
         n++;
      end
      checkCycles("testConfigLoad configDone", 2 * SrBits + 1, n);  // Two cycles per bit
      checkConfig("testConfigLoad word", cfg, scConfigT'(capturedWord));
   endtask

   task automatic testReadRegLoad();
      logic [SrBits-1:0] mask;
      int n;
      mask = {$urandom, $urandom};
      readReg = mask;
      scOrRead = 1'b1;
      startLoad = 1'b1;
      nextCycle();
      startLoad = 1'b0;
      checkBit("testReadRegLoad select", 1'b1, select);
      n = 0;
      while (!configDone) begin
         nextCycle();
         n++;
      end
      checkCycles("testReadRegLoad configDone", 2 * SrBits + 1, n);
      checkReadReg("testReadRegLoad word", mask, capturedWord);
   endtask

   task automatic testAcquisition();
      int n;
      wordGap = 2;
      queueWords(5);                           // Sent on the coming startReadout
      acqTime = 16'd20;
      acqStart = 1'b1;
      nextCycle();
      acqStart = 1'b0;
      checkPower("testAcquisition power on", pwrOnT'(4'hF), pwrOn);
      n = 0;
      while (!startAcq) begin
         nextCycle();
         n++;
      end
      checkCycles("testAcquisition settle", PwrSettle, n);
      n = 0;
      while (startAcq) begin
         checkBit("testAcquisition early readout", 1'b0, startReadout);
         n++;
         nextCycle();
      end
      checkCycles("testAcquisition startAcq width", 20, n);
      checkBit("testAcquisition startReadout", 1'b1, startReadout);
      nextCycle();
      checkBit("testAcquisition startReadout pulse", 1'b0, startReadout);
   endtask

   task automatic testReadoutData();
      waitCycleEnd("testReadoutData");
      checkReceived("testReadoutData", 1);
   endtask

   task automatic testBackPressure();
      fifoQ.delete();
      wordGap = 24;                            // Buffer drains before the next word
      queueWords(3);
      fifoFull = 1'b1;
      acqTime = 16'd20;
      acqStart = 1'b1;
      nextCycle();
      acqStart = 1'b0;
      while (!startReadout)
         nextCycle();
      repeat (30) begin                        // First word parks in the buffer
         nextCycle();
         if (fifoWrEn) begin
            $display("fifoWrEn went high while fifoFull was held high");
            abortRun();
         end
      end
      fifoFull = 1'b0;
      waitCycleEnd("testBackPressure");
      checkReceived("testBackPressure", 2);
      checkBit("testBackPressure overflow", 1'b0, overflow);
   endtask

   task automatic testHold();
      int n;
      holdEn = 1'b1;
      holdDelay = 8'd5;
      holdTime = 16'd12;
      nextCycle();
      trigIn = 1'b1;
      nextCycle();                             // Edge taken here
      n = 0;
      while (!hold) begin
         nextCycle();
         n++;
      end
      checkCycles("testHold delay", 5 + 1, n);
      n = 0;
      while (hold) begin
         n++;
         if (n == 3)
            trigIn = 1'b0;
         if (n == 5)
            trigIn = 1'b1;                     // Second trigger inside the window
         nextCycle();
      end
      checkCycles("testHold width", 12, n);
      repeat (20) begin
         checkBit("testHold retrigger", 1'b0, hold);
         nextCycle();
      end
      trigIn = 1'b0;
      holdEn = 1'b0;
      nextCycle();
      trigIn = 1'b1;
      repeat (20) begin
         nextCycle();
         checkBit("testHold disabled", 1'b0, hold);
      end
      trigIn = 1'b0;
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      arstN = 1'b0;
      scOrRead = 1'b0;
      startLoad = 1'b0;
      scConfig = '0;
      readReg = '0;
      acqStart = 1'b0;
      acqTime = '0;
      holdTime = '0;
      holdDelay = '0;
      holdEn = 1'b0;
      trigIn = 1'b0;
      fifoFull = 1'b0;
      void'($urandom(Seed));
      repeat (ResetCycles) @(posedge Clk);
      #1;
      checkBit("reset srRstB", 1'b0, srRstB);  // ASIC register held with the FPGA
      arstN = 1'b1;
      nextCycle();
      checkBit("reset srRstB release", 1'b1, srRstB);
      testConfigLoad();
      testReadRegLoad();
      testAcquisition();
      testReadoutData();
      testBackPressure();
      testHold();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire
